//--- build.f
rtl/mipsPkg.sv
rtl/unifiedMemory.sv
rtl/registerFile.sv
rtl/alu.sv
rtl/controlFsm.sv
rtl/mipsSystem.sv
testbench/mipsSystemTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module mipsSystemTb -f build.f -o simv &&
./obj_dir/simv || { echo "run.sh: build or simulation failed"; exit 1; }

//--- testbench/mipsSystemTb.sv
`timescale 1ns/100ps

module mipsSystemTb
    import mipsPkg::*;
();

    localparam int MEM_WORDS     = 1024;
    localparam int RESET_PC      = 128;
    localparam int CLK_PERIOD_NS = 10;
    localparam int RESET_CYCLES  = 5;

    // Executed instructions over all tests at up to 5 cycles each
    localparam int EXEC_INSTRS     = 120;
    // Loads, dumps, resets and idle waits
    localparam int OVERHEAD_CYCLES = 800;
    localparam int WATCHDOG_NS     = (EXEC_INSTRS * 5 + OVERHEAD_CYCLES) * CLK_PERIOD_NS;

    logic                  clk;
    logic                  arstN;
    logic                  run;
    logic                  loadEnable;
    logic [DATA_WIDTH-1:0] loadAddress;
    logic [DATA_WIDTH-1:0] loadData;
    logic [DATA_WIDTH-1:0] dumpAddress;
    logic [DATA_WIDTH-1:0] dumpData;
    logic                  halted;
    logic [DATA_WIDTH-1:0] pc;

    // Fibonacci LFSR state
    logic [15:0]           lfsrState = 16'd27;
    // Program under construction for RESET_PC onward
    logic [DATA_WIDTH-1:0] progWords[$];

    mipsSystem #(.MEM_WORDS(MEM_WORDS), .RESET_PC(RESET_PC)) uut (
        .clk(clk), .arstN(arstN), .run(run), .loadEnable(loadEnable),
        .loadAddress(loadAddress), .loadData(loadData), .dumpAddress(dumpAddress),
        .dumpData(dumpData), .halted(halted), .pc(pc)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_NS);
        abortRun("Watchdog expired before the tests finished");
    end

    ////////////////////////////////////////////////////////////
    // Failure reporting and compare tasks
    ////////////////////////////////////////////////////////////
    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic checkWord(input string name, input logic [DATA_WIDTH-1:0] expected,
                             input logic [DATA_WIDTH-1:0] actual);
        if (actual !== expected)
        begin
            abortRun($sformatf("Error: %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            abortRun($sformatf("Error: %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // FSM state compare that also names the states
    task automatic checkState(input string name, input cpuStateT expected,
                              input cpuStateT actual);
        if (actual !== expected)
        begin
            abortRun($sformatf("Error: %s expected %h (%s) actual %h (%s)", name,
                               expected, expected.name(), actual, actual.name()));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Random operands
    ////////////////////////////////////////////////////////////

    // Taps 16, 14, 13, 11
    function automatic logic nextRandomBit();
        logic feedback;
        feedback  = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
        lfsrState = {lfsrState[14:0], feedback};
        return feedback;
    endfunction

    function automatic logic [DATA_WIDTH-1:0] randomBits(input int count);
        logic [DATA_WIDTH-1:0] value;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            value = {value[DATA_WIDTH-2:0], nextRandomBit()};
        end
        return value;
    endfunction

    ////////////////////////////////////////////////////////////
    // Instruction encoders
    ////////////////////////////////////////////////////////////
    function automatic instrT encodeR(input functT fn, input logic [4:0] rd,
                                      input logic [4:0] rs, input logic [4:0] rt);
        instrT word;
        word.rType.opcode = OP_RTYPE;
        word.rType.rs     = rs;
        word.rType.rt     = rt;
        word.rType.rd     = rd;
        word.rType.shamt  = 5'd0;
        word.rType.funct  = fn;
        return word;
    endfunction

    // Argument order follows assembly with rt first
    function automatic instrT encodeI(input opcodeT op, input logic [4:0] rt,
                                      input logic [4:0] rs, input logic [15:0] imm);
        instrT word;
        word.iType.opcode = op;
        word.iType.rs     = rs;
        word.iType.rt     = rt;
        word.iType.imm    = imm;
        return word;
    endfunction

    function automatic instrT encodeJ(input logic [DATA_WIDTH-1:0] target);
        instrT word;
        word              = '0;
        word.iType.opcode = OP_J;
        word[25:0]        = target[27:2];
        return word;
    endfunction

    function automatic instrT encodeHalt();
        instrT word;
        word              = '0;
        word.iType.opcode = OP_HALT;
        return word;
    endfunction

    // Word offset relative to the following instruction
    function automatic logic [15:0] branchOffset(input int fromAddr, input int toAddr);
        return 16'((toAddr - (fromAddr + 4)) / 4);
    endfunction

    ////////////////////////////////////////////////////////////
    // Test port and run control
    ////////////////////////////////////////////////////////////
    task automatic resetCore();
        @(posedge clk);
        arstN      <= 1'b0;
        run        <= 1'b0;
        loadEnable <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
    endtask

    // Write lands on the second edge
    task automatic loadWord(input logic [DATA_WIDTH-1:0] address,
                            input logic [DATA_WIDTH-1:0] data);
        @(posedge clk);
        loadEnable  <= 1'b1;
        loadAddress <= address;
        loadData    <= data;
        @(posedge clk);
        loadEnable <= 1'b0;
    endtask

    task automatic addInstr(input instrT word);
        progWords.push_back(word);
    endtask

    task automatic loadProgram();
        foreach (progWords[i])
        begin
            loadWord(DATA_WIDTH'(RESET_PC + 4 * i), progWords[i]);
        end
        progWords.delete();
    endtask

    task automatic runUntilHalted();
        @(posedge clk);
        run <= 1'b1;
        @(negedge clk);
        while (halted !== 1'b1)
        begin
            @(negedge clk);
        end
        @(posedge clk);
        run <= 1'b0;
        @(negedge clk);
    endtask

    task automatic checkMemory(input string name, input logic [DATA_WIDTH-1:0] address,
                               input logic [DATA_WIDTH-1:0] expected);
        @(posedge clk);
        dumpAddress <= address;
        @(negedge clk);
        checkWord(name, expected, dumpData);
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    // Random operands loaded by lw, combined by five R-type ops and stored by sw
    task automatic testRType();
        logic [DATA_WIDTH-1:0] opA;
        logic [DATA_WIDTH-1:0] opB;
        logic [DATA_WIDTH-1:0] sltAB;
        logic [DATA_WIDTH-1:0] sltBA;
        opA   = randomBits(32);
        opB   = randomBits(32);
        sltAB = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
        sltBA = ($signed(opB) < $signed(opA)) ? 32'd1 : 32'd0;
        resetCore();
        loadWord(32'h800, opA);
        loadWord(32'h804, opB);
        addInstr(encodeI(OP_LW, 5'd1, 5'd0, 16'h0800));
        addInstr(encodeI(OP_LW, 5'd2, 5'd0, 16'h0804));
        addInstr(encodeR(FN_ADD, 5'd3, 5'd1, 5'd2));
        addInstr(encodeI(OP_SW, 5'd3, 5'd0, 16'h0808));
        addInstr(encodeR(FN_SUB, 5'd4, 5'd1, 5'd2));
        addInstr(encodeI(OP_SW, 5'd4, 5'd0, 16'h080c));
        addInstr(encodeR(FN_AND, 5'd5, 5'd1, 5'd2));
        addInstr(encodeI(OP_SW, 5'd5, 5'd0, 16'h0810));
        addInstr(encodeR(FN_OR, 5'd6, 5'd1, 5'd2));
        addInstr(encodeI(OP_SW, 5'd6, 5'd0, 16'h0814));
        addInstr(encodeR(FN_SLT, 5'd7, 5'd1, 5'd2));
        addInstr(encodeI(OP_SW, 5'd7, 5'd0, 16'h0818));
        addInstr(encodeR(FN_SLT, 5'd8, 5'd2, 5'd1));
        addInstr(encodeI(OP_SW, 5'd8, 5'd0, 16'h081c));
        addInstr(encodeHalt());
        loadProgram();
        runUntilHalted();
        checkMemory("add result", 32'h808, opA + opB);
        checkMemory("sub result", 32'h80c, opA - opB);
        checkMemory("and result", 32'h810, opA & opB);
        checkMemory("or result", 32'h814, opA | opB);
        checkMemory("slt a<b result", 32'h818, sltAB);
        checkMemory("slt b<a result", 32'h81c, sltBA);
    endtask

    task automatic testImmediate();
        logic [15:0]           immPos;
        logic [15:0]           immNeg;
        logic [DATA_WIDTH-1:0] sumPos;
        logic [DATA_WIDTH-1:0] sumNeg;
        immPos = 16'd1234;
        // -300
        immNeg = 16'hfed4;
        sumPos = DATA_WIDTH'(1234);
        sumNeg = DATA_WIDTH'(1234 - 300);
        resetCore();
        // Stale nonzero marker that the r0 store overwrites
        loadWord(32'h900, randomBits(32) | 32'h1);
        addInstr(encodeI(OP_ADDI, 5'd1, 5'd0, immPos));
        addInstr(encodeI(OP_ADDI, 5'd2, 5'd1, immNeg));
        addInstr(encodeI(OP_ADDI, 5'd3, 5'd0, 16'hffff));
        addInstr(encodeI(OP_ADDI, 5'd0, 5'd0, 16'h0037));
        addInstr(encodeR(FN_ADD, 5'd0, 5'd1, 5'd2));
        addInstr(encodeI(OP_SW, 5'd0, 5'd0, 16'h0900));
        addInstr(encodeI(OP_SW, 5'd1, 5'd0, 16'h0904));
        addInstr(encodeI(OP_SW, 5'd2, 5'd0, 16'h0908));
        addInstr(encodeI(OP_SW, 5'd3, 5'd0, 16'h090c));
        addInstr(encodeHalt());
        loadProgram();
        runUntilHalted();
        checkMemory("register 0", 32'h900, 32'h0);
        checkMemory("addi positive", 32'h904, sumPos);
        checkMemory("addi negative", 32'h908, sumNeg);
        checkMemory("addi minus one", 32'h90c, 32'hffffffff);
    endtask

    // Countdown loop followed by a beq that must fall through
    task automatic testBranchLoop();
        int count;
        count = int'(randomBits(4)) + 3;
        resetCore();
        loadWord(32'ha00, randomBits(32));
        loadWord(32'ha04, 32'h0);
        addInstr(encodeI(OP_ADDI, 5'd1, 5'd0, 16'(count)));
        addInstr(encodeI(OP_ADDI, 5'd2, 5'd0, 16'h0000));
        addInstr(encodeI(OP_ADDI, 5'd3, 5'd0, 16'hffff));
        // Loop head at 140
        addInstr(encodeI(OP_BEQ, 5'd0, 5'd1, branchOffset(140, 160)));
        addInstr(encodeR(FN_ADD, 5'd2, 5'd2, 5'd1));
        addInstr(encodeR(FN_ADD, 5'd1, 5'd1, 5'd3));
        addInstr(encodeI(OP_BEQ, 5'd0, 5'd0, branchOffset(152, 140)));
        // Never reached at 156
        addInstr(encodeHalt());
        // Loop exit at 160
        addInstr(encodeI(OP_SW, 5'd2, 5'd0, 16'h0a00));
        addInstr(encodeI(OP_BEQ, 5'd0, 5'd2, branchOffset(164, 176)));
        addInstr(encodeI(OP_ADDI, 5'd4, 5'd0, 16'd77));
        addInstr(encodeI(OP_SW, 5'd4, 5'd0, 16'h0a04));
        // 176
        addInstr(encodeHalt());
        loadProgram();
        runUntilHalted();
        checkMemory("loop sum", 32'ha00, DATA_WIDTH'(count * (count + 1) / 2));
        checkMemory("fall-through marker", 32'ha04, 32'd77);
        checkWord("pc", DATA_WIDTH'(176 + 4), pc);
    endtask

    task automatic testJumpHalt();
        logic [DATA_WIDTH-1:0] marker;
        int                    haltCycles;
        marker = randomBits(32);
        // addi, j and sw, then fetch and decode of halt
        haltCycles = 4 + 3 + 4 + 2;
        resetCore();
        loadWord(32'hb00, marker);
        loadWord(32'hb04, 32'h0);
        addInstr(encodeI(OP_ADDI, 5'd1, 5'd0, 16'h0055));
        addInstr(encodeJ(32'd144));
        // Skipped by the jump
        addInstr(encodeI(OP_SW, 5'd1, 5'd0, 16'h0b00));
        addInstr(encodeHalt());
        // Jump target at 144
        addInstr(encodeI(OP_SW, 5'd1, 5'd0, 16'h0b04));
        addInstr(encodeHalt());
        loadProgram();
        // Halted rises exactly when the last state of the sequence ends
        @(posedge clk);
        run <= 1'b1;
        repeat (haltCycles - 1) @(posedge clk);
        @(negedge clk);
        checkFlag("halted before halt state", 1'b0, halted);
        @(negedge clk);
        checkFlag("halted", 1'b1, halted);
        @(posedge clk);
        run <= 1'b0;
        @(negedge clk);
        checkMemory("marker", 32'hb00, marker);
        checkMemory("jump landing", 32'hb04, 32'h55);
        checkWord("pc", DATA_WIDTH'(148 + 4), pc);
    endtask

    task automatic testRunControl();
        logic [DATA_WIDTH-1:0] words[8];
        logic [DATA_WIDTH-1:0] probe;
        resetCore();
        // Program would clobber the first data word if it ran
        addInstr(encodeI(OP_SW, 5'd0, 5'd0, 16'h0c00));
        addInstr(encodeHalt());
        loadProgram();
        foreach (words[i])
        begin
            words[i] = randomBits(32);
            loadWord(DATA_WIDTH'(32'hc00 + 4 * i), words[i]);
        end
        // Dump visible in the cycle right after the write edge
        probe = randomBits(32);
        @(posedge clk);
        loadEnable  <= 1'b1;
        loadAddress <= 32'hc40;
        loadData    <= probe;
        dumpAddress <= 32'hc40;
        @(posedge clk);
        loadEnable <= 1'b0;
        @(negedge clk);
        checkWord("dump after write", probe, dumpData);
        // Core idle with run low
        repeat (20) @(posedge clk);
        foreach (words[i])
        begin
            checkMemory("stopped word", DATA_WIDTH'(32'hc00 + 4 * i), words[i]);
        end
        checkWord("pc", DATA_WIDTH'(RESET_PC), pc);
        checkFlag("halted", 1'b0, halted);
        checkState("state", S_FETCH, uut.control.state);
        runUntilHalted();
        checkMemory("core store", 32'hc00, 32'h0);
        checkMemory("neighbour word", 32'hc04, words[1]);
        resetCore();
        checkWord("pc after reset", DATA_WIDTH'(RESET_PC), pc);
        checkFlag("halted after reset", 1'b0, halted);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial
    begin
        arstN       <= 1'b0;
        run         <= 1'b0;
        loadEnable  <= 1'b0;
        loadAddress <= '0;
        loadData    <= '0;
        dumpAddress <= '0;
        testRType();
        testImmediate();
        testBranchLoop();
        testJumpHalt();
        testRunControl();
        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- rtl/mipsSystem.sv
`timescale 1ns/100ps

module mipsSystem
    import mipsPkg::*;
#(
    parameter int MEM_WORDS = 1024,
    parameter int RESET_PC  = 128
)
(
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  run,
    input  logic                  loadEnable,
    input  logic [DATA_WIDTH-1:0] loadAddress,
    input  logic [DATA_WIDTH-1:0] loadData,
    input  logic [DATA_WIDTH-1:0] dumpAddress,
    output logic [DATA_WIDTH-1:0] dumpData,
    output logic                  halted,
    output logic [DATA_WIDTH-1:0] pc
);

    // Controls
    logic       pcWrite, irWrite, memWrite, regWrite;
    logic       iorD, regDst, memToReg, aluSrcA;
    logic [1:0] aluSrcB, pcSource;
    aluOpT      aluOp;

    // Datapath registers
    instrT                 ir;
    logic [DATA_WIDTH-1:0] mdr, regA, regB, aluOut;

    // Datapath nets
    logic [DATA_WIDTH-1:0] memAddress, memWriteData, memReadData;
    logic                  memWriteEnable;
    logic [DATA_WIDTH-1:0] coreAddress, signExtImm, jumpTarget, nextPc;
    logic [DATA_WIDTH-1:0] rfDataA, rfDataB, rfWriteData, aluA, aluB, aluResult;
    logic [4:0]            rfWriteAddr;
    logic                  aluZero;

    ////////////////////////////////////////////////////////////
    // Program counter and instruction register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            pc <= DATA_WIDTH'(RESET_PC);
            ir <= '0;
        end
        else
        begin
            if (pcWrite)
                pc <= nextPc;
            if (irWrite)
                ir <= instrT'(memReadData);
        end
    end

    // Scratch registers, frozen while stopped so a resume picks up cleanly
    always_ff @(posedge clk)
    begin
        if (run)
        begin
            mdr    <= memReadData;
            regA   <= rfDataA;
            regB   <= rfDataB;
            aluOut <= aluResult;
        end
    end

    // Immediate and jump target
    assign signExtImm = {{16{ir.iType.imm[15]}}, ir.iType.imm};
    assign jumpTarget = {pc[31:28], ir[25:0], 2'b00};

    // Instruction or data address
    assign coreAddress = iorD ? aluOut : pc;

    // Write register and write data
    assign rfWriteAddr = regDst ? ir.rType.rd : ir.rType.rt;
    assign rfWriteData = memToReg ? mdr : aluOut;

    // ALU operands
    assign aluA = aluSrcA ? regA : pc;
    always_comb
    begin
        case (aluSrcB)
            2'b00:   aluB = regB;
            2'b01:   aluB = DATA_WIDTH'(4);
            2'b10:   aluB = signExtImm;
            default: aluB = {signExtImm[DATA_WIDTH-3:0], 2'b00};
        endcase
    end

    // Next PC
    always_comb
    begin
        case (pcSource)
            2'b01:   nextPc = aluOut;
            2'b10:   nextPc = jumpTarget;
            default: nextPc = aluResult;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Memory port, test port owns it while run is low
    ////////////////////////////////////////////////////////////
    assign memAddress     = run ? coreAddress : loadAddress;
    assign memWriteData   = run ? regB : loadData;
    assign memWriteEnable = run ? memWrite : loadEnable;

    unifiedMemory #(.MEM_WORDS(MEM_WORDS)) memory (
        .clk(clk), .writeEnable(memWriteEnable), .address(memAddress),
        .writeData(memWriteData), .dumpAddress(dumpAddress),
        .readData(memReadData), .dumpData(dumpData)
    );

    registerFile regFile (
        .clk(clk), .arstN(arstN), .writeEnable(regWrite),
        .readAddrA(ir.rType.rs), .readAddrB(ir.rType.rt), .writeAddr(rfWriteAddr),
        .writeData(rfWriteData), .readDataA(rfDataA), .readDataB(rfDataB)
    );

    alu mainAlu (
        .op(aluOp), .a(aluA), .b(aluB), .result(aluResult), .zero(aluZero)
    );

    controlFsm control (
        .clk(clk), .arstN(arstN), .run(run),
        .opcode(ir.rType.opcode), .funct(ir.rType.funct), .aluZero(aluZero),
        .pcWrite(pcWrite), .irWrite(irWrite), .memWrite(memWrite), .regWrite(regWrite),
        .iorD(iorD), .regDst(regDst), .memToReg(memToReg), .aluSrcA(aluSrcA),
        .aluSrcB(aluSrcB), .pcSource(pcSource), .aluOp(aluOp), .halted(halted)
    );

    // Loads only happen with the core stopped
    loadOnlyStopped: assert property (@(posedge clk) disable iff (!arstN)
        loadEnable |-> !run)
        else $error("loadEnable high while run is high");

endmodule

//--- rtl/controlFsm.sv
`timescale 1ns/100ps

module controlFsm
    import mipsPkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    input  logic       run,
    input  opcodeT     opcode,
    input  functT      funct,
    input  logic       aluZero,
    output logic       pcWrite,
    output logic       irWrite,
    output logic       memWrite,
    output logic       regWrite,
    output logic       iorD,
    output logic       regDst,
    output logic       memToReg,
    output logic       aluSrcA,
    output logic [1:0] aluSrcB,
    output logic [1:0] pcSource,
    output aluOpT      aluOp,
    output logic       halted
);

    cpuStateT state;
    cpuStateT nextState;

    ////////////////////////////////////////////////////////////
    // State register
    ////////////////////////////////////////////////////////////

    // Only advances while run is high
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            state <= S_FETCH;
        end
        else if (run)
        begin
            state <= nextState;
        end
    end

    // Next state
    always_comb
    begin
        nextState = S_FETCH;
        case (state)
            S_FETCH:    nextState = S_DECODE;
            S_DECODE:
            begin
                // Opcode dispatch
                case (opcode)
                    OP_RTYPE: nextState = S_EXECUTE;
                    OP_LW:    nextState = S_MEMADDR;
                    OP_SW:    nextState = S_MEMADDR;
                    OP_ADDI:  nextState = S_ADDIEXEC;
                    OP_BEQ:   nextState = S_BRANCH;
                    OP_J:     nextState = S_JUMP;
                    // Halt and anything unknown
                    default:  nextState = S_HALT;
                endcase
            end
            S_MEMADDR:  nextState = (opcode == OP_LW) ? S_MEMREAD : S_MEMWRITE;
            S_MEMREAD:  nextState = S_MEMWB;
            S_EXECUTE:  nextState = S_ALUWB;
            S_ADDIEXEC: nextState = S_ADDIWB;
            // Sticky until reset
            S_HALT:     nextState = S_HALT;
            default:    nextState = S_FETCH;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Datapath controls
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        // Everything idle unless a state says otherwise
        pcWrite  = 1'b0;
        irWrite  = 1'b0;
        memWrite = 1'b0;
        regWrite = 1'b0;
        iorD     = 1'b0;
        regDst   = 1'b0;
        memToReg = 1'b0;
        aluSrcA  = 1'b0;
        aluSrcB  = 2'b00;
        pcSource = 2'b00;
        aluOp    = ALU_ADD;
        if (run)
        begin
            case (state)
                S_FETCH:
                begin
                    // IR from memory, PC + 4
                    irWrite = 1'b1;
                    aluSrcB = 2'b01;
                    pcWrite = 1'b1;
                end
                S_DECODE:
                begin
                    // Branch target into ALUOut early
                    aluSrcB = 2'b11;
                end
                S_MEMADDR:
                begin
                    aluSrcA = 1'b1;
                    aluSrcB = 2'b10;
                end
                S_MEMREAD:  iorD = 1'b1;
                S_MEMWB:
                begin
                    memToReg = 1'b1;
                    regWrite = 1'b1;
                end
                S_MEMWRITE:
                begin
                    iorD     = 1'b1;
                    memWrite = 1'b1;
                end
                S_EXECUTE:
                begin
                    aluSrcA = 1'b1;
                    // Funct picks the operation
                    case (funct)
                        FN_SUB:  aluOp = ALU_SUB;
                        FN_AND:  aluOp = ALU_AND;
                        FN_OR:   aluOp = ALU_OR;
                        FN_SLT:  aluOp = ALU_SLT;
                        default: aluOp = ALU_ADD;
                    endcase
                end
                S_ALUWB:
                begin
                    regDst   = 1'b1;
                    regWrite = 1'b1;
                end
                S_BRANCH:
                begin
                    // Compare rs and rt, take ALUOut if equal
                    aluSrcA  = 1'b1;
                    aluOp    = ALU_SUB;
                    pcSource = 2'b01;
                    pcWrite  = aluZero;
                end
                S_ADDIEXEC:
                begin
                    aluSrcA = 1'b1;
                    aluSrcB = 2'b10;
                end
                S_ADDIWB:   regWrite = 1'b1;
                S_JUMP:
                begin
                    pcSource = 2'b10;
                    pcWrite  = 1'b1;
                end
                default:
                begin
                    // Halt drives nothing
                end
            endcase
        end
    end

    assign halted = (state == S_HALT);

    // IR loads in fetch only
    irWriteInFetch: assert property (@(posedge clk) disable iff (!arstN)
        irWrite |-> state == S_FETCH)
        else $error("irWrite outside fetch in state %s", state.name());

    // Stopped core writes nothing
    noWriteWhileStopped: assert property (@(posedge clk) disable iff (!arstN)
        !run |-> !(pcWrite || irWrite || memWrite || regWrite))
        else $error("write enable high with run low");

endmodule

//--- rtl/alu.sv
`timescale 1ns/100ps

module alu
    import mipsPkg::*;
(
    input  aluOpT                 op,
    input  logic [DATA_WIDTH-1:0] a,
    input  logic [DATA_WIDTH-1:0] b,
    output logic [DATA_WIDTH-1:0] result,
    output logic                  zero
);

    // Signed views for slt
    logic signed [DATA_WIDTH-1:0] aSigned;
    logic signed [DATA_WIDTH-1:0] bSigned;

    assign aSigned = a;
    assign bSigned = b;

    ////////////////////////////////////////////////////////////
    // Operation select
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        case (op)
            ALU_ADD:
            begin
                result = a + b;
            end
            ALU_SUB:
            begin
                // Also the beq compare
                result = a - b;
            end
            ALU_AND:
            begin
                result = a & b;
            end
            ALU_OR:
            begin
                result = a | b;
            end
            ALU_SLT:
            begin
                // 1 or 0, signed compare
                result = {{(DATA_WIDTH-1){1'b0}}, (aSigned < bSigned)};
            end
            default:
            begin
                result = '0;
            end
        endcase
    end

    // Branch condition flag
    assign zero = (result == '0);

endmodule

//--- rtl/registerFile.sv
`timescale 1ns/100ps

module registerFile
    import mipsPkg::*;
(
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  writeEnable,
    input  logic [4:0]            readAddrA,
    input  logic [4:0]            readAddrB,
    input  logic [4:0]            writeAddr,
    input  logic [DATA_WIDTH-1:0] writeData,
    output logic [DATA_WIDTH-1:0] readDataA,
    output logic [DATA_WIDTH-1:0] readDataB
);

    // General purpose registers
    logic [DATA_WIDTH-1:0] regs [32];

    // Clear on reset, register 0 never written
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (writeEnable && (writeAddr != 5'd0))
        begin
            regs[writeAddr] <= writeData;
        end
    end

    // Both reads combinational
    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

    // Register 0 is hardwired zero
    regZeroStable: assert property (@(posedge clk) disable iff (!arstN)
        regs[0] == '0)
        else $error("register 0 changed to %h", regs[0]);

endmodule

//--- rtl/unifiedMemory.sv
`timescale 1ns/100ps

module unifiedMemory
    import mipsPkg::*;
#(
    parameter int MEM_WORDS = 1024
)
(
    input  logic                  clk,
    input  logic                  writeEnable,
    input  logic [DATA_WIDTH-1:0] address,
    input  logic [DATA_WIDTH-1:0] writeData,
    input  logic [DATA_WIDTH-1:0] dumpAddress,
    output logic [DATA_WIDTH-1:0] readData,
    output logic [DATA_WIDTH-1:0] dumpData
);

    // Word index bits above the byte offset
    localparam int INDEX_BITS = $clog2(MEM_WORDS);

    // Shared store for instructions and data
    logic [DATA_WIDTH-1:0] mem [MEM_WORDS];

    logic [INDEX_BITS-1:0] coreIndex;
    logic [INDEX_BITS-1:0] dumpIndex;

    // Drop the byte offset
    assign coreIndex = address[INDEX_BITS+1:2];
    assign dumpIndex = dumpAddress[INDEX_BITS+1:2];

    ////////////////////////////////////////////////////////////
    // Write port, one word per edge
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (writeEnable)
        begin
            mem[coreIndex] <= writeData;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////////////////////////

    // Core side, fetch and load
    assign readData = mem[coreIndex];

    // Test side, valid at any time
    assign dumpData = mem[dumpIndex];

    // Writes must hit a whole word inside the array
    writeAddressOk: assert property (@(posedge clk)
        writeEnable |-> (address[1:0] == 2'b00) && ((address >> 2) < MEM_WORDS))
        else $error("memory write to bad address %h", address);

endmodule

//--- rtl/mipsPkg.sv
package mipsPkg;

    ////////////////////////////////////////////////////////////
    // Datapath width
    ////////////////////////////////////////////////////////////
    localparam int DATA_WIDTH = 32;

    ////////////////////////////////////////////////////////////
    // Instruction encodings
    ////////////////////////////////////////////////////////////

    // Primary opcodes, MIPS values where they exist
    typedef enum logic [5:0]
    {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b,
        // Stops the core until reset
        OP_HALT  = 6'h3f
    } opcodeT;

    // R-type funct field
    typedef enum logic [5:0]
    {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } functT;

    // Shared ALU operations
    typedef enum logic [2:0]
    {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } aluOpT;

    // Multicycle control states
    typedef enum logic [3:0]
    {
        S_FETCH    = 4'd0,
        S_DECODE   = 4'd1,
        S_MEMADDR  = 4'd2,
        S_MEMREAD  = 4'd3,
        S_MEMWB    = 4'd4,
        S_MEMWRITE = 4'd5,
        S_EXECUTE  = 4'd6,
        S_ALUWB    = 4'd7,
        S_BRANCH   = 4'd8,
        S_ADDIEXEC = 4'd9,
        S_ADDIWB   = 4'd10,
        S_JUMP     = 4'd11,
        S_HALT     = 4'd12
    } cpuStateT;

    // Instruction word, seen as R-type or I-type fields
    // Jump target is just the low 26 bits
    typedef union packed
    {
        struct packed
        {
            opcodeT      opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [4:0]  rd;
            logic [4:0]  shamt;
            functT       funct;
        } rType;
        struct packed
        {
            opcodeT      opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } iType;
    } instrT;

endpackage
